// ==== include/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Bits handled per clock
`define NIB_W 4

// Architectural word width
`define XLEN 32

// Register file address width
`define REG_AW 5

// Nibbles per word
`define NIB_CNT 8

// Nibble counter width
`define CNT_W 3

`endif

// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

   // Major opcodes of the supported subset
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111
   } opcode_e;

   // funct3 values shared by OP and OP-IMM
   typedef enum logic [2:0] {
      F3_ADD_SUB = 3'b000,
      F3_SLT     = 3'b010,
      F3_SLTU    = 3'b011,
      F3_XOR     = 3'b100,
      F3_OR      = 3'b110,
      F3_AND     = 3'b111
   } funct3_e;

   // funct7 for sub
   localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage

// ==== src/serial_core_pkg.sv ====
`include "core_defines.svh"

package serial_core_pkg;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DECODE,
      ST_RUN,
      ST_WRITE
   } seq_state_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU
   } alu_op_e;

   typedef logic [`NIB_W-1:0]  nibble_t;
   typedef logic [`XLEN-1:0]   word_t;
   typedef logic [`REG_AW-1:0] reg_addr_t;

   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    utype;
      logic    rf_wen;
      logic    illegal;
   } exec_ctrl_t;

endpackage

// ==== src/operand_if.sv ====
`include "core_defines.svh"

interface operand_if;
   import serial_core_pkg::*;

   logic [`CNT_W-1:0] nib_idx;
   logic              run;
   logic              first;
   logic              last;
   nibble_t           rs1_nib;
   nibble_t           rs2_nib;
   nibble_t           imm_nib;

   modport seq (output nib_idx, output run, output first, output last);

   modport rf  (input nib_idx, output rs1_nib, output rs2_nib);

   modport imm (input nib_idx, output imm_nib);

   modport alu (input run, input first, input last,
                input rs1_nib, input rs2_nib, input imm_nib);

endinterface

// ==== src/serial_decode.sv ====
module serial_decode (
   input  logic                       clk,
   input  logic                       i_instr_valid,
   input  serial_core_pkg::word_t     i_instr,
   input  logic                       i_ready,
   output serial_core_pkg::exec_ctrl_t o_ctrl,
   output serial_core_pkg::word_t     o_instr,
   output serial_core_pkg::reg_addr_t o_rs1,
   output serial_core_pkg::reg_addr_t o_rs2,
   output serial_core_pkg::reg_addr_t o_rd
);
   import rv_isa_pkg::*;
   import serial_core_pkg::*;

   opcode_e    opcode;
   funct3_e    funct3;
   logic [6:0] funct7;
   logic       bad;
   exec_ctrl_t ctrl_d;
   exec_ctrl_t ctrl_q;
   word_t      instr_q;

   assign opcode = opcode_e'(i_instr[6:0]);
   assign funct3 = funct3_e'(i_instr[14:12]);
   assign funct7 = i_instr[31:25];

   always_comb begin
      ctrl_d = '{alu_op: ALU_ADD, use_imm: 1'b0, utype: 1'b0, rf_wen: 1'b1, illegal: 1'b0};
      bad    = 1'b0;
      case (opcode)
         OPC_LUI: begin
            ctrl_d.use_imm = 1'b1;
            ctrl_d.utype   = 1'b1;
         end
         OPC_OP, OPC_OP_IMM: begin
            ctrl_d.use_imm = (opcode == OPC_OP_IMM);
            // Register ops need a clean funct7, except sub
            if (opcode == OPC_OP && funct7 != 7'd0 &&
                !(funct7 == F7_ALT && funct3 == F3_ADD_SUB))
               bad = 1'b1;
            case (funct3)
               F3_ADD_SUB: ctrl_d.alu_op = (opcode == OPC_OP && funct7 == F7_ALT) ?
                                           ALU_SUB : ALU_ADD;
               F3_SLT:     ctrl_d.alu_op = ALU_SLT;
               F3_SLTU:    ctrl_d.alu_op = ALU_SLTU;
               F3_XOR:     ctrl_d.alu_op = ALU_XOR;
               F3_OR:      ctrl_d.alu_op = ALU_OR;
               F3_AND:     ctrl_d.alu_op = ALU_AND;
               // Shifts are not supported
               default:    bad = 1'b1;
            endcase
         end
         default: bad = 1'b1;
      endcase
      ctrl_d.illegal = bad;
      ctrl_d.rf_wen  = !bad;
   end

   always_ff @(posedge clk) begin
      if (i_instr_valid && i_ready) begin
         instr_q <= i_instr;
         ctrl_q  <= ctrl_d;
      end
   end

   assign o_ctrl  = ctrl_q;
   assign o_instr = instr_q;
   // LUI adds its immediate to x0
   assign o_rs1   = ctrl_q.utype ? '0 : instr_q[19:15];
   assign o_rs2   = instr_q[24:20];
   assign o_rd    = instr_q[11:7];

endmodule

// ==== src/serial_sequencer.sv ====
`include "core_defines.svh"

module serial_sequencer (
   input  logic                        clk,
   input  logic                        i_rst_n,
   input  logic                        i_instr_valid,
   input  serial_core_pkg::exec_ctrl_t i_ctrl,
   output logic                        o_ready,
   output logic                        o_wb_valid,
   output logic                        o_illegal,
   operand_if.seq                      ops
);
   import serial_core_pkg::*;

   localparam logic [`CNT_W-1:0] LAST_NIB = `CNT_W'(`NIB_CNT - 1);

   seq_state_e        state;
   logic [`CNT_W-1:0] cnt;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state <= ST_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (i_instr_valid)
                  state <= ST_DECODE;
            end
            ST_DECODE: begin
               state <= ST_RUN;
               cnt   <= '0;
            end
            ST_RUN: begin
               // Counter wraps back to zero after the top nibble
               cnt <= cnt + 1'b1;
               if (cnt == LAST_NIB)
                  state <= ST_WRITE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign ops.nib_idx = cnt;
   assign ops.run     = (state == ST_RUN);
   assign ops.first   = ops.run && (cnt == '0);
   assign ops.last    = ops.run && (cnt == LAST_NIB);

   assign o_ready    = (state == ST_IDLE);
   assign o_wb_valid = (state == ST_WRITE) && !i_ctrl.illegal;
   assign o_illegal  = (state == ST_WRITE) && i_ctrl.illegal;

endmodule

// ==== src/serial_regfile.sv ====
`include "core_defines.svh"

module serial_regfile (
   input  logic                       clk,
   input  serial_core_pkg::reg_addr_t i_rs1,
   input  serial_core_pkg::reg_addr_t i_rs2,
   input  serial_core_pkg::reg_addr_t i_rd,
   input  logic                       i_wen,
   input  serial_core_pkg::word_t     i_wdata,
   operand_if.rf                      ops
);
   import serial_core_pkg::*;

   localparam int NREGS = 2 ** `REG_AW;

   word_t regs [NREGS];
   word_t rs1_word;
   word_t rs2_word;

   // x0 is never stored, so its reads are forced to zero
   always_comb begin
      if (i_rs1 == '0)
         rs1_word = '0;
      else
         rs1_word = regs[i_rs1];
   end

   always_comb begin
      if (i_rs2 == '0)
         rs2_word = '0;
      else
         rs2_word = regs[i_rs2];
   end

   // Operand nibbles follow the sequencer count, LSB first
   assign ops.rs1_nib = rs1_word[ops.nib_idx * `NIB_W +: `NIB_W];
   assign ops.rs2_nib = rs2_word[ops.nib_idx * `NIB_W +: `NIB_W];

   // Whole word written in the write-back cycle
   always_ff @(posedge clk) begin
      if (i_wen && i_rd != '0)
         regs[i_rd] <= i_wdata;
   end

endmodule

// ==== src/imm_serializer.sv ====
`include "core_defines.svh"

module imm_serializer (
   input  serial_core_pkg::word_t      i_instr,
   input  serial_core_pkg::exec_ctrl_t i_ctrl,
   operand_if.imm                      ops
);
   import serial_core_pkg::*;

   word_t imm_i;
   word_t imm_u;
   word_t imm;

   // I-type immediate sign extended from bit 31
   assign imm_i = {{(`XLEN - 12){i_instr[31]}}, i_instr[31:20]};

   // U-type keeps the upper 20 bits
   assign imm_u = {i_instr[31:12], 12'd0};

   assign imm = i_ctrl.utype ? imm_u : imm_i;

   assign ops.imm_nib = imm[ops.nib_idx * `NIB_W +: `NIB_W];

endmodule

// ==== src/serial_alu.sv ====
`include "core_defines.svh"

module serial_alu (
   input  logic                        clk,
   input  serial_core_pkg::exec_ctrl_t i_ctrl,
   operand_if.alu                      ops,
   output serial_core_pkg::word_t      o_result
);
   import serial_core_pkg::*;

   nibble_t        op_a;
   nibble_t        op_b;
   nibble_t        b_in;
   nibble_t        res_nib;
   logic [`NIB_W:0] sum;
   logic           sub_like;
   logic           is_cmp;
   logic           cin;
   logic           carry_q;
   logic           lt;
   word_t          result_q;

   assign op_a = ops.rs1_nib;
   assign op_b = i_ctrl.use_imm ? ops.imm_nib : ops.rs2_nib;

   assign is_cmp   = (i_ctrl.alu_op == ALU_SLT) || (i_ctrl.alu_op == ALU_SLTU);
   assign sub_like = (i_ctrl.alu_op == ALU_SUB) || is_cmp;

   // Subtraction as a + ~b + 1 with the +1 entering on the first nibble
   assign b_in = sub_like ? ~op_b : op_b;
   assign cin  = ops.first ? sub_like : carry_q;
   assign sum  = {1'b0, op_a} + {1'b0, b_in} + {{`NIB_W{1'b0}}, cin};

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_AND: res_nib = op_a & op_b;
         ALU_OR:  res_nib = op_a | op_b;
         ALU_XOR: res_nib = op_a ^ op_b;
         default: res_nib = sum[`NIB_W-1:0];
      endcase
   end

   // No carry out of the top nibble means a borrow, so a < b unsigned.
   // With differing signs, signed order is just the sign of a.
   always_comb begin
      if (i_ctrl.alu_op == ALU_SLTU || op_a[`NIB_W-1] == op_b[`NIB_W-1])
         lt = !sum[`NIB_W];
      else
         lt = op_a[`NIB_W-1];
   end

   always_ff @(posedge clk) begin
      if (ops.run) begin
         carry_q <= sum[`NIB_W];
         if (ops.last && is_cmp)
            result_q <= {{(`XLEN - 1){1'b0}}, lt};
         else
            result_q <= {res_nib, result_q[`XLEN-1:`NIB_W]};
      end
   end

   assign o_result = result_q;

endmodule

// ==== src/serial_core_top.sv ====
module serial_core_top (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_instr_valid,
   input  serial_core_pkg::word_t     i_instr,
   output logic                       o_ready,
   output logic                       o_wb_valid,
   output serial_core_pkg::reg_addr_t o_wb_addr,
   output serial_core_pkg::word_t     o_wb_data,
   output logic                       o_illegal
);
   import serial_core_pkg::*;

   exec_ctrl_t ctrl;
   word_t      instr;
   word_t      result;
   reg_addr_t  rs1;
   reg_addr_t  rs2;
   reg_addr_t  rd;
   logic       rf_wen;

   operand_if ops ();

   serial_decode u_decode (
      .clk           (clk),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .i_ready       (o_ready),
      .o_ctrl        (ctrl),
      .o_instr       (instr),
      .o_rs1         (rs1),
      .o_rs2         (rs2),
      .o_rd          (rd)
   );

   serial_sequencer u_sequencer (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_instr_valid (i_instr_valid),
      .i_ctrl        (ctrl),
      .o_ready       (o_ready),
      .o_wb_valid    (o_wb_valid),
      .o_illegal     (o_illegal),
      .ops           (ops.seq)
   );

   // Register write only on a legal write-back
   assign rf_wen = o_wb_valid && ctrl.rf_wen;

   serial_regfile u_regfile (
      .clk     (clk),
      .i_rs1   (rs1),
      .i_rs2   (rs2),
      .i_rd    (rd),
      .i_wen   (rf_wen),
      .i_wdata (result),
      .ops     (ops.rf)
   );

   imm_serializer u_imm (
      .i_instr (instr),
      .i_ctrl  (ctrl),
      .ops     (ops.imm)
   );

   serial_alu u_alu (
      .clk      (clk),
      .i_ctrl   (ctrl),
      .ops      (ops.alu),
      .o_result (result)
   );

   assign o_wb_addr = rd;
   assign o_wb_data = result;

endmodule

// ==== testbench/serial_core_props.sv ====
module serial_core_props (
   input logic clk,
   input logic i_rst_n,
   input logic i_instr_valid,
   input logic i_ready,
   input logic i_wb_valid,
   input logic i_illegal
);

   logic accept;
   logic done;
   int   fail_count = 0;

   assign accept = i_instr_valid && i_ready;
   assign done   = i_wb_valid || i_illegal;

   // One kind of result per instruction
   a_one_kind: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_wb_valid && i_illegal))
      else begin
         fail_count++;
         $error("write-back and illegal pulses high together");
      end

   a_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
      accept |=> (!done) [*9] ##1 done)
      else begin
         fail_count++;
         $error("result pulse not 10 cycles after acceptance");
      end

   a_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
      accept |=> (!i_ready) [*10] ##1 i_ready)
      else begin
         fail_count++;
         $error("ready not low for the whole instruction");
      end

endmodule

bind serial_core_top serial_core_props u_props (
   .clk           (clk),
   .i_rst_n       (i_rst_n),
   .i_instr_valid (i_instr_valid),
   .i_ready       (o_ready),
   .i_wb_valid    (o_wb_valid),
   .i_illegal     (o_illegal)
);

// ==== testbench/tb_serial_core.sv ====
`include "core_defines.svh"

module tb_serial_core;
   import rv_isa_pkg::*;
   import serial_core_pkg::*;

   localparam int CLK_PERIOD  = 4;
   localparam int RESULT_EDGE = `NIB_CNT + 2;
   localparam int N_LOAD      = 62;
   localparam int N_REG       = 40;
   localparam int N_IMM       = 40;
   localparam int N_CMP_DIR   = 12;
   localparam int N_CMP_RAND  = 24;
   localparam int N_X0        = 5;
   localparam int N_ILL       = 11;
   localparam int N_TOTAL     = N_LOAD + N_REG + N_IMM + N_CMP_DIR + N_CMP_RAND + N_X0 + N_ILL;
   // Each instruction takes 11 cycles plus a few for issue and drain
   localparam int TIMEOUT     = (N_TOTAL * (RESULT_EDGE + 4) + 200) * CLK_PERIOD;

   logic      clk;
   logic      i_rst_n;
   logic      i_instr_valid;
   word_t     i_instr;
   logic      o_ready;
   logic      o_wb_valid;
   reg_addr_t o_wb_addr;
   word_t     o_wb_data;
   logic      o_illegal;

   logic [31:0] lfsr = 32'd4;
   word_t       ref_regs [32];
   int          cyc = 0;
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          failed_tests = 0;

   // Outstanding instructions in issue order
   string       exp_name [$];
   reg_addr_t   exp_rd [$];
   word_t       exp_data [$];
   logic        exp_ill [$];
   int          exp_acc [$];

   serial_core_top u_serial_core_top (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .o_ready       (o_ready),
      .o_wb_valid    (o_wb_valid),
      .o_wb_addr     (o_wb_addr),
      .o_wb_data     (o_wb_data),
      .o_illegal     (o_illegal)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          k;
      v = '0;
      for (k = 0; k < n; k++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
      return v;
   endfunction

   function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd,
                                   input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd);
      return {imm, rd, OPC_LUI};
   endfunction

   // RV32I rules for the supported subset, on the model register file
   function automatic word_t ref_exec(input word_t instr, output reg_addr_t rd,
                                      output logic ill);
      word_t      a;
      word_t      b;
      logic [6:0] opc;
      logic [6:0] f7;
      logic [2:0] f3;
      opc = instr[6:0];
      f7  = instr[31:25];
      f3  = instr[14:12];
      rd  = instr[11:7];
      ill = 1'b0;
      a   = ref_regs[instr[19:15]];
      b   = (opc == OPC_OP) ? ref_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
      if (opc == OPC_LUI)
         return {instr[31:12], 12'd0};
      ill = 1'b1;
      if (opc != OPC_OP && opc != OPC_OP_IMM)
         return '0;
      if (opc == OPC_OP && f7 != 7'd0 && !(f7 == F7_ALT && f3 == 3'b000))
         return '0;
      ill = 1'b0;
      case (f3)
         3'b000:  return (opc == OPC_OP && f7 == F7_ALT) ? a - b : a + b;
         3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'b011:  return (a < b) ? 32'd1 : 32'd0;
         3'b100:  return a ^ b;
         3'b110:  return a | b;
         3'b111:  return a & b;
         default: begin
            ill = 1'b1;
            return '0;
         end
      endcase
   endfunction

   task automatic issue(input word_t instr, input string name);
      word_t     data;
      word_t     noise;
      reg_addr_t rd;
      logic      ill;
      logic      use_noise;
      data = ref_exec(instr, rd, ill);
      if (!ill && rd != '0)
         ref_regs[rd] = data;
      noise     = rand_bits(32);
      use_noise = (rand_bits(1) != 0);
      @(negedge clk);
      while (!o_ready)
         @(negedge clk);
      @(posedge clk);
      i_instr_valid <= 1'b1;
      i_instr       <= instr;
      @(posedge clk);
      // Junk held on the bus while busy must be ignored
      if (use_noise)
         i_instr <= noise;
      else
         i_instr_valid <= 1'b0;
      @(negedge clk);
      if (o_ready) begin
         errors++;
         $display("%s was not accepted although the core was ready", name);
      end
      exp_name.push_back(name);
      exp_rd.push_back(rd);
      exp_data.push_back(data);
      exp_ill.push_back(ill);
      exp_acc.push_back(cyc);
      if (use_noise) begin
         repeat (7) @(posedge clk);
         i_instr_valid <= 1'b0;
      end
   endtask

   task automatic finish_test(input string name, input int n, input int err0);
      while (exp_name.size() != 0)
         @(negedge clk);
      @(negedge clk);
      tests++;
      if (errors == err0) begin
         $display("[PASS] %s: %0d instructions", name, n);
      end else begin
         failed_tests++;
         $display("[FAIL] %s: %0d instructions, %0d errors", name, n, errors - err0);
      end
   endtask

   task automatic load_regs();
      int err0;
      int r;
      err0 = errors;
      for (r = 1; r < 32; r++) begin
         issue(enc_u(20'(rand_bits(20)), reg_addr_t'(r)), $sformatf("lui_x%0d", r));
         issue(enc_i(12'(rand_bits(12)), reg_addr_t'(r), F3_ADD_SUB, reg_addr_t'(r),
                     OPC_OP_IMM), $sformatf("addi_x%0d", r));
      end
      finish_test("reg_load", N_LOAD, err0);
   endtask

   // kind 0 register ops, 1 immediate ops, 2 compares
   task automatic random_ops(input string tname, input int kind, input int n);
      int          err0;
      int          i;
      int          sel;
      reg_addr_t   rs1;
      reg_addr_t   rs2;
      reg_addr_t   rd;
      logic [11:0] imm;
      logic [2:0]  f3;
      logic [6:0]  f7;
      word_t       instr;
      err0 = errors;
      for (i = 0; i < n; i++) begin
         rs1 = reg_addr_t'(rand_bits(5));
         rs2 = reg_addr_t'(rand_bits(5));
         rd  = reg_addr_t'(rand_bits(5));
         imm = 12'(rand_bits(12));
         f7  = 7'd0;
         sel = int'(rand_bits(3));
         if (kind == 2) begin
            if (rand_bits(1) != 0)
               rs2 = rs1;
            f3 = sel[0] ? F3_SLTU : F3_SLT;
            if (sel[1])
               instr = enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
            else
               instr = enc_r(f7, rs2, rs1, f3, rd);
         end else begin
            case (sel % 6)
               0:       f3 = F3_ADD_SUB;
               1:       f3 = F3_AND;
               2:       f3 = F3_OR;
               3:       f3 = F3_XOR;
               4:       f3 = (kind == 0) ? F3_ADD_SUB : F3_SLT;
               default: f3 = (kind == 0) ? F3_XOR : F3_SLTU;
            endcase
            if (kind == 0 && f3 == F3_ADD_SUB && rand_bits(1) != 0)
               f7 = F7_ALT;
            if (kind == 0)
               instr = enc_r(f7, rs2, rs1, f3, rd);
            else
               instr = enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
         end
         issue(instr, $sformatf("%s#%0d", tname, i));
      end
      finish_test(tname, n, err0);
   endtask

   // Outputs are compared mid-cycle
   always @(negedge clk) begin
      if (i_rst_n && (o_wb_valid || o_illegal)) begin
         if (exp_name.size() == 0) begin
            errors++;
            $display("A result pulse came with no instruction outstanding");
         end else begin
            checks++;
            if (exp_ill[0]) begin
               if (!o_illegal || o_wb_valid) begin
                  errors++;
                  $display("[ERROR] %s: illegal/wb_valid expected 1/0 actual %0d/%0d",
                           exp_name[0], o_illegal, o_wb_valid);
               end
            end else if (!o_wb_valid || o_illegal) begin
               errors++;
               $display("[ERROR] %s: wb_valid/illegal expected 1/0 actual %0d/%0d",
                        exp_name[0], o_wb_valid, o_illegal);
            end else begin
               if (o_wb_addr != exp_rd[0]) begin
                  errors++;
                  $display("[ERROR] %s: rd expected %0d actual %0d",
                           exp_name[0], exp_rd[0], o_wb_addr);
               end
               if (o_wb_data != exp_data[0]) begin
                  errors++;
                  $display("[ERROR] %s: data expected 0x%08h actual 0x%08h",
                           exp_name[0], exp_data[0], o_wb_data);
               end
            end
            if (cyc + 1 != exp_acc[0] + RESULT_EDGE) begin
               errors++;
               $display("%s: result came %0d cycles after acceptance instead of %0d",
                        exp_name[0], cyc + 1 - exp_acc[0], RESULT_EDGE);
            end
            void'(exp_name.pop_front());
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
            void'(exp_ill.pop_front());
            void'(exp_acc.pop_front());
         end
      end
   end

   initial begin
      #(TIMEOUT);
      $display("Watchdog expired after %0d time units, the core stopped responding", TIMEOUT);
      $display("Verification failed");
      $finish;
   end

   initial begin
      int err0;
      clk           = 1'b0;
      i_rst_n       = 1'b0;
      i_instr_valid = 1'b0;
      i_instr       = '0;
      ref_regs[0]   = '0;
      repeat (2) @(posedge clk);
      i_rst_n <= 1'b1;

      load_regs();
      random_ops("reg_ops", 0, N_REG);
      random_ops("imm_ops", 1, N_IMM);

      // Most negative value against one in both orders
      err0 = errors;
      issue(enc_u(20'h80000, 5'd10), "lui_min");
      issue(enc_i(12'd1, 5'd0, F3_ADD_SUB, 5'd11, OPC_OP_IMM), "addi_one");
      issue(enc_r(7'd0, 5'd11, 5'd10, F3_SLT, 5'd12), "slt_neg_pos");
      issue(enc_r(7'd0, 5'd11, 5'd10, F3_SLTU, 5'd13), "sltu_neg_pos");
      issue(enc_r(7'd0, 5'd10, 5'd11, F3_SLT, 5'd14), "slt_pos_neg");
      issue(enc_r(7'd0, 5'd10, 5'd11, F3_SLTU, 5'd15), "sltu_pos_neg");
      issue(enc_r(7'd0, 5'd10, 5'd10, F3_SLT, 5'd16), "slt_equal");
      issue(enc_r(7'd0, 5'd11, 5'd11, F3_SLTU, 5'd17), "sltu_equal");
      issue(enc_i(12'hfff, 5'd10, F3_SLT, 5'd18, OPC_OP_IMM), "slti_neg");
      issue(enc_i(12'hfff, 5'd11, F3_SLTU, 5'd19, OPC_OP_IMM), "sltiu_neg");
      issue(enc_i(12'h7ff, 5'd10, F3_SLTU, 5'd20, OPC_OP_IMM), "sltiu_max");
      issue(enc_i(12'd1, 5'd11, F3_SLT, 5'd21, OPC_OP_IMM), "slti_equal");
      finish_test("compare_edges", N_CMP_DIR, err0);

      random_ops("compare_random", 2, N_CMP_RAND);

      err0 = errors;
      issue(enc_r(7'd0, 5'd2, 5'd1, F3_ADD_SUB, 5'd0), "add_to_x0");
      issue(enc_i(12'h123, 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM), "addi_to_x0");
      issue(enc_i(12'd0, 5'd0, F3_ADD_SUB, 5'd22, OPC_OP_IMM), "read_x0");
      issue(enc_r(7'd0, 5'd1, 5'd0, F3_OR, 5'd23), "or_x0");
      issue(enc_r(F7_ALT, 5'd1, 5'd0, F3_ADD_SUB, 5'd24), "sub_from_x0");
      finish_test("x0_write", N_X0, err0);

      // Unsupported encodings followed by reads of their destinations
      err0 = errors;
      issue({12'h004, 5'd1, 3'b010, 5'd5, 7'b0000011}, "load");
      issue(enc_i(12'd0, 5'd5, F3_ADD_SUB, 5'd25, OPC_OP_IMM), "read_x5");
      issue(enc_i(12'd3, 5'd6, 3'b001, 5'd6, OPC_OP_IMM), "slli");
      issue(enc_i({7'b0100000, 5'd2}, 5'd7, 3'b101, 5'd7, OPC_OP_IMM), "srai");
      issue(enc_r(F7_ALT, 5'd1, 5'd8, 3'b101, 5'd8), "sra");
      issue(enc_r(7'b0000001, 5'd2, 5'd1, F3_ADD_SUB, 5'd8), "mul");
      issue(enc_r(F7_ALT, 5'd2, 5'd1, F3_XOR, 5'd6), "xor_alt_funct7");
      issue({7'd0, 5'd2, 5'd1, 3'b000, 5'd0, 7'b1100011}, "beq");
      issue(32'd0, "all_zero");
      issue(enc_r(7'd0, 5'd7, 5'd6, F3_XOR, 5'd26), "read_x6_x7");
      issue(enc_r(7'd0, 5'd0, 5'd8, F3_OR, 5'd27), "read_x8");
      finish_test("illegal", N_ILL, err0);

      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
               tests, failed_tests, checks, errors, u_serial_core_top.u_props.fail_count);
      if (errors == 0 && u_serial_core_top.u_props.fail_count == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+include
src/rv_isa_pkg.sv
src/serial_core_pkg.sv
src/operand_if.sv
src/serial_decode.sv
src/serial_sequencer.sv
src/serial_regfile.sv
src/imm_serializer.sv
src/serial_alu.sv
src/serial_core_top.sv
testbench/serial_core_props.sv
testbench/tb_serial_core.sv
